// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

        typedef logic [31:0] word_t;
        typedef logic [25:0] tag_t;
        typedef logic [2:0]  idx_t;
        typedef logic        way_t;

        localparam int SETS = 2 ** $bits(idx_t);

        // Processor address as the cache sees it
        typedef struct packed {
                tag_t       tag;
                idx_t       idx;
                logic       blkoff;
                logic [1:0] bytoff;
        } dcache_addr_t;

        typedef struct packed {
                logic         valid;
                logic         dirty;
                tag_t         tag;
                word_t [1:0]  data;
        } frame_t;

        typedef frame_t [1:0] frame_pair_t; // Indexed by way

        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t store;
        } cpu_req_t;

        typedef struct packed {
                logic  hit;
                word_t load;
                logic  flushed;
        } cpu_rsp_t;

        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t store;
        } mem_req_t;

        typedef struct packed {
                logic  dwait;
                word_t load;
        } mem_rsp_t;

        typedef enum logic [2:0] {
                FOP_NONE,
                FOP_STORE,
                FOP_FILL,
                FOP_VALIDATE,
                FOP_CLEAN,
                FOP_CLEAR
        } frame_op_t;

        typedef struct packed {
                frame_op_t op;
                way_t      way;
                idx_t      idx;
                logic      sel;
                tag_t      tag;
                word_t     data;
        } frame_wr_t;

        typedef enum logic [3:0] {
                LOOKUP,
                WB_LO,
                WB_HI,
                FILL_LO,
                FILL_HI,
                SCAN,
                SCAN_WB_LO,
                SCAN_WB_HI,
                COUNT_STORE,
                FLUSHED
        } ctrl_state_t;

endpackage

// ==== hw/dcache_tag_lookup.sv ====
module dcache_tag_lookup
        import dcache_pkg::*;
(
        input  logic        CLK,
        input  logic        nRST,
        input  word_t       addr,
        input  frame_pair_t set_frames,
        input  logic        touch,
        input  way_t        touch_way,
        output logic        hit,
        output way_t        hit_way,
        output way_t        victim_way,
        output tag_t        victim_tag,
        output logic        victim_dirty
);

        dcache_addr_t     fields;
        logic [1:0]       way_hit;
        logic [SETS-1:0]  lru;  // Most recently used way of each set

        assign fields = dcache_addr_t'(addr);

        assign way_hit[0] = set_frames[0].valid && (set_frames[0].tag == fields.tag);
        assign way_hit[1] = set_frames[1].valid && (set_frames[1].tag == fields.tag);

        assign hit     = |way_hit;
        assign hit_way = !way_hit[0]; // Way 0 wins if both would match

        // Replace the way that was not used last
        assign victim_way   = !lru[fields.idx];
        assign victim_tag   = set_frames[victim_way].tag;
        assign victim_dirty = set_frames[victim_way].valid && set_frames[victim_way].dirty;

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        lru <= '0;
                end else if (touch) begin
                        lru[fields.idx] <= touch_way;
                end
        end

endmodule

// ==== hw/dcache_frames.sv ====
module dcache_frames
        import dcache_pkg::*;
(
        input  logic        CLK,
        input  logic        nRST,
        input  idx_t        rd_idx,
        input  frame_wr_t   frame_wr,
        output frame_pair_t set_frames
);

        frame_pair_t frames [SETS];

        assign set_frames = frames[rd_idx];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int s = 0; s < SETS; s++) begin
                                frames[s] <= '0;
                        end
                end else begin
                        case (frame_wr.op)
                                FOP_STORE: begin
                                        frames[frame_wr.idx][frame_wr.way].data[frame_wr.sel] <=
                                                frame_wr.data;
                                        frames[frame_wr.idx][frame_wr.way].valid <= 1'b1;
                                        frames[frame_wr.idx][frame_wr.way].dirty <= 1'b1;
                                end
                                FOP_FILL: begin
                                        // Frame stays invalid until its last word arrives
                                        frames[frame_wr.idx][frame_wr.way].tag <= frame_wr.tag;
                                        frames[frame_wr.idx][frame_wr.way].data[frame_wr.sel] <=
                                                frame_wr.data;
                                        frames[frame_wr.idx][frame_wr.way].valid <= 1'b0;
                                        frames[frame_wr.idx][frame_wr.way].dirty <= 1'b0;
                                end
                                FOP_VALIDATE: begin
                                        frames[frame_wr.idx][frame_wr.way].tag <= frame_wr.tag;
                                        frames[frame_wr.idx][frame_wr.way].data[frame_wr.sel] <=
                                                frame_wr.data;
                                        frames[frame_wr.idx][frame_wr.way].valid <= 1'b1;
                                        frames[frame_wr.idx][frame_wr.way].dirty <= 1'b0;
                                end
                                FOP_CLEAN: begin
                                        frames[frame_wr.idx][frame_wr.way].dirty <= 1'b0;
                                end
                                FOP_CLEAR: begin
                                        frames[frame_wr.idx][frame_wr.way] <= '0;
                                end
                                default: begin
                                end
                        endcase
                end
        end

endmodule

// ==== hw/dcache_control.sv ====
module dcache_control
        import dcache_pkg::*;
#(
        parameter word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
        input  logic        CLK,
        input  logic        nRST,
        input  cpu_req_t    cpu_req,
        input  logic        halt,
        output cpu_rsp_t    cpu_rsp,
        output mem_req_t    mem_req,
        input  mem_rsp_t    mem_rsp,
        input  logic        hit,
        input  way_t        hit_way,
        input  way_t        victim_way,
        input  tag_t        victim_tag,
        input  logic        victim_dirty,
        input  frame_pair_t set_frames,
        output logic        touch,
        output way_t        touch_way,
        output idx_t        rd_idx,
        output frame_wr_t   frame_wr
);

        ctrl_state_t  state, state_n;
        idx_t         scan_idx, scan_idx_n;
        way_t         scan_way, scan_way_n;
        word_t        hit_count, hit_count_n;

        dcache_addr_t req_addr;
        logic         req;
        frame_t       victim_frame;
        frame_t       scan_frame;
        logic         scan_step;

        function automatic word_t block_addr(tag_t tag, idx_t idx, logic sel);
                return {tag, idx, sel, 2'b00};
        endfunction

        assign req_addr     = dcache_addr_t'(cpu_req.addr);
        assign req          = cpu_req.ren || cpu_req.wen;
        assign victim_frame = set_frames[victim_way];
        assign scan_frame   = set_frames[scan_way];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state     <= LOOKUP;
                        scan_idx  <= '0;
                        scan_way  <= '0;
                        hit_count <= '0;
                end else begin
                        state     <= state_n;
                        scan_idx  <= scan_idx_n;
                        scan_way  <= scan_way_n;
                        hit_count <= hit_count_n;
                end
        end

        always_comb begin
                state_n         = state;
                scan_idx_n      = scan_idx;
                scan_way_n      = scan_way;
                hit_count_n     = hit_count;
                scan_step       = 1'b0;
                cpu_rsp.hit     = 1'b0;
                cpu_rsp.load    = set_frames[hit_way].data[req_addr.blkoff];
                cpu_rsp.flushed = (state == FLUSHED);
                mem_req         = '0;
                touch           = 1'b0;
                touch_way       = hit_way;
                rd_idx          = req_addr.idx;
                frame_wr        = '0;
                frame_wr.op     = FOP_NONE;
                frame_wr.way    = victim_way;
                frame_wr.idx    = req_addr.idx;
                frame_wr.tag    = req_addr.tag;
                frame_wr.data   = mem_rsp.load;

                case (state)
                        LOOKUP: begin
                                if (halt) begin
                                        state_n    = SCAN;
                                        scan_idx_n = '0;
                                        scan_way_n = '0;
                                end else if (req && hit) begin
                                        cpu_rsp.hit = 1'b1;
                                        touch       = 1'b1;
                                        hit_count_n = hit_count + 1;
                                        if (cpu_req.wen) begin
                                                frame_wr.op   = FOP_STORE;
                                                frame_wr.way  = hit_way;
                                                frame_wr.sel  = req_addr.blkoff;
                                                frame_wr.data = cpu_req.store;
                                        end
                                end else if (req) begin
                                        // The refill hit will count this request back up
                                        hit_count_n = hit_count - 1;
                                        state_n     = victim_dirty ? WB_LO : FILL_LO;
                                end
                        end
                        WB_LO: begin
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = block_addr(victim_tag, req_addr.idx, 1'b0);
                                mem_req.store = victim_frame.data[0];
                                if (!mem_rsp.dwait) begin
                                        state_n = WB_HI;
                                end
                        end
                        WB_HI: begin
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = block_addr(victim_tag, req_addr.idx, 1'b1);
                                mem_req.store = victim_frame.data[1];
                                if (!mem_rsp.dwait) begin
                                        frame_wr.op = FOP_CLEAN;
                                        state_n     = FILL_LO;
                                end
                        end
                        FILL_LO: begin
                                mem_req.ren  = 1'b1;
                                mem_req.addr = block_addr(req_addr.tag, req_addr.idx, 1'b0);
                                if (!mem_rsp.dwait) begin
                                        frame_wr.op  = FOP_FILL;
                                        frame_wr.sel = 1'b0;
                                        state_n      = FILL_HI;
                                end
                        end
                        FILL_HI: begin
                                mem_req.ren  = 1'b1;
                                mem_req.addr = block_addr(req_addr.tag, req_addr.idx, 1'b1);
                                if (!mem_rsp.dwait) begin
                                        frame_wr.op  = FOP_VALIDATE;
                                        frame_wr.sel = 1'b1;
                                        state_n      = LOOKUP;
                                end
                        end
                        SCAN: begin
                                rd_idx = scan_idx;
                                if (scan_frame.valid && scan_frame.dirty) begin
                                        state_n = SCAN_WB_LO;
                                end else begin
                                        scan_step = 1'b1;
                                end
                        end
                        SCAN_WB_LO: begin
                                rd_idx        = scan_idx;
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = block_addr(scan_frame.tag, scan_idx, 1'b0);
                                mem_req.store = scan_frame.data[0];
                                if (!mem_rsp.dwait) begin
                                        state_n = SCAN_WB_HI;
                                end
                        end
                        SCAN_WB_HI: begin
                                rd_idx        = scan_idx;
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = block_addr(scan_frame.tag, scan_idx, 1'b1);
                                mem_req.store = scan_frame.data[1];
                                scan_step     = !mem_rsp.dwait;
                        end
                        COUNT_STORE: begin
                                mem_req.wen   = 1'b1;
                                mem_req.addr  = HIT_COUNT_ADDR;
                                mem_req.store = hit_count;
                                if (!mem_rsp.dwait) begin
                                        state_n = FLUSHED;
                                end
                        end
                        FLUSHED: begin
                        end
                        default: begin
                                state_n = LOOKUP;
                        end
                endcase

                // The scan goes set by set and takes way 0 before way 1
                if (scan_step) begin
                        frame_wr.op  = FOP_CLEAR;
                        frame_wr.way = scan_way;
                        frame_wr.idx = scan_idx;
                        {scan_idx_n, scan_way_n} = {scan_idx, scan_way} + 1'b1;
                        state_n = (&{scan_idx, scan_way}) ? COUNT_STORE : SCAN;
                end
        end

endmodule

// ==== hw/dcache.sv ====
module dcache
        import dcache_pkg::*;
#(
        parameter word_t HIT_COUNT_ADDR = 32'h0000_3100
) (
        input  logic     CLK,
        input  logic     nRST,
        input  cpu_req_t cpu_req,
        input  logic     halt,
        output cpu_rsp_t cpu_rsp,
        output mem_req_t mem_req,
        input  mem_rsp_t mem_rsp
);

        frame_pair_t set_frames;
        frame_wr_t   frame_wr;
        idx_t        rd_idx;
        logic        hit;
        way_t        hit_way;
        way_t        victim_way;
        tag_t        victim_tag;
        logic        victim_dirty;
        logic        touch;
        way_t        touch_way;

        dcache_tag_lookup lookup (
                .CLK          (CLK),
                .nRST         (nRST),
                .addr         (cpu_req.addr),
                .set_frames   (set_frames),
                .touch        (touch),
                .touch_way    (touch_way),
                .hit          (hit),
                .hit_way      (hit_way),
                .victim_way   (victim_way),
                .victim_tag   (victim_tag),
                .victim_dirty (victim_dirty)
        );

        dcache_frames frames (
                .CLK        (CLK),
                .nRST       (nRST),
                .rd_idx     (rd_idx),
                .frame_wr   (frame_wr),
                .set_frames (set_frames)
        );

        dcache_control #(
                .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
        ) control (
                .CLK          (CLK),
                .nRST         (nRST),
                .cpu_req      (cpu_req),
                .halt         (halt),
                .cpu_rsp      (cpu_rsp),
                .mem_req      (mem_req),
                .mem_rsp      (mem_rsp),
                .hit          (hit),
                .hit_way      (hit_way),
                .victim_way   (victim_way),
                .victim_tag   (victim_tag),
                .victim_dirty (victim_dirty),
                .set_frames   (set_frames),
                .touch        (touch),
                .touch_way    (touch_way),
                .rd_idx       (rd_idx),
                .frame_wr     (frame_wr)
        );

endmodule

// ==== verification/dcache_mem_model.sv ====
module dcache_mem_model
        import dcache_pkg::*;
#(
        parameter word_t SEED = 32'haffe
) (
        input  logic     CLK,
        input  logic     nRST,
        input  mem_req_t mem_req,
        output mem_rsp_t mem_rsp
);
        timeunit 1ns;
        timeprecision 100ps;

        localparam int DEPTH = 4096; // Word index is addr[13:2]

        word_t      mem [DEPTH];
        word_t      seed;
        word_t      next_seed;
        logic [1:0] delay;  // Wait cycles left before the current access completes
        logic       access;

        function automatic word_t lcg_next(word_t s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic word_t fill_pattern(word_t a);
                return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
        endfunction

        task automatic read_word(input word_t addr, output word_t data);
                data = mem[addr[13:2]];
        endtask

        assign access        = mem_req.ren || mem_req.wen;
        assign next_seed     = lcg_next(seed);
        assign mem_rsp.dwait = access && (delay != 2'd0);
        assign mem_rsp.load  = mem[mem_req.addr[13:2]];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                mem[i] <= fill_pattern(word_t'(i) << 2);
                        end
                        seed  <= SEED;
                        delay <= '0;
                end else if (access) begin
                        if (delay != 2'd0) begin
                                delay <= delay - 2'd1;
                        end else begin
                                if (mem_req.wen) begin
                                        mem[mem_req.addr[13:2]] <= mem_req.store;
                                end
                                seed  <= next_seed;
                                delay <= next_seed[31:30]; // Upper LCG bits vary the most
                        end
                end
        end

endmodule

// ==== verification/dcache_tb.sv ====
module dcache_tb
        import dcache_pkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        typedef struct packed {
                logic  wr;
                word_t addr;
                word_t data;
        } step_t;

        localparam word_t HIT_COUNT_ADDR = 32'h0000_3100;
        localparam int    NUM_STEPS      = 20;
        localparam int    MAX_CYCLES     = 10 + NUM_STEPS * 20 + 2 * SETS * 10 + 20;

        // Sets 0 and 1 take hits and stores and set 2 takes three blocks for eviction
        localparam step_t STEPS [NUM_STEPS] = '{
                '{1'b0, 32'h0000_0100, 32'h0000_0000},
                '{1'b0, 32'h0000_0100, 32'h0000_0000},
                '{1'b0, 32'h0000_0104, 32'h0000_0000},
                '{1'b1, 32'h0000_0208, 32'haaaa_0001},
                '{1'b0, 32'h0000_0208, 32'h0000_0000},
                '{1'b1, 32'h0000_020c, 32'hbbbb_0002},
                '{1'b1, 32'h0000_0208, 32'hcccc_0003}, // Second store to a dirty block
                '{1'b0, 32'h0000_0208, 32'h0000_0000},
                '{1'b0, 32'h0000_020c, 32'h0000_0000},
                '{1'b1, 32'h0000_0010, 32'hdddd_0004},
                '{1'b1, 32'h0000_0050, 32'heeee_0005},
                '{1'b0, 32'h0000_0010, 32'h0000_0000},
                '{1'b1, 32'h0000_0090, 32'hffff_0006},
                '{1'b0, 32'h0000_0050, 32'h0000_0000},
                '{1'b0, 32'h0000_0014, 32'h0000_0000},
                '{1'b0, 32'h0000_0010, 32'h0000_0000},
                '{1'b0, 32'h0000_0094, 32'h0000_0000},
                '{1'b1, 32'h0000_3f00, 32'h1234_0007},
                '{1'b0, 32'h0000_0100, 32'h0000_0000},
                '{1'b0, 32'h0000_3f00, 32'h0000_0000}
        };

        logic     CLK;
        logic     nRST;
        logic     halt;
        cpu_req_t cpu_req;
        cpu_rsp_t cpu_rsp;
        mem_req_t mem_req;
        mem_rsp_t mem_rsp;

        logic  model_valid [SETS][2];
        tag_t  model_tag   [SETS][2];
        way_t  model_mru   [SETS];
        int    model_hits = 0;
        word_t gold [word_t];  // Expected memory contents by byte address
        int    checks = 0;
        int    errors = 0;

        dcache #(.HIT_COUNT_ADDR(HIT_COUNT_ADDR)) UUT (
                .CLK     (CLK),
                .nRST    (nRST),
                .cpu_req (cpu_req),
                .halt    (halt),
                .cpu_rsp (cpu_rsp),
                .mem_req (mem_req),
                .mem_rsp (mem_rsp)
        );

        dcache_mem_model mem_model (
                .CLK     (CLK),
                .nRST    (nRST),
                .mem_req (mem_req),
                .mem_rsp (mem_rsp)
        );

        task automatic check_word(input string name, input word_t actual, input word_t expected);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s is %h, expected %h",
                                 $time, name, actual, expected);
                end
        endtask

        task automatic check_flag(input string name, input logic actual, input logic expected);
                checks++;
                if (actual !== expected) begin
                        errors++;
                        $display("CHECK FAILED at %0t: %s is %b, expected %b",
                                 $time, name, actual, expected);
                end
        endtask

        // Tag and LRU model of one access where a miss installs the block in the LRU way
        task automatic predict_access(input word_t addr, output logic exp_hit);
                tag_t t;
                idx_t i;
                way_t w;
                t = addr[31:6];
                i = addr[5:3];
                exp_hit = 1'b1;
                if (model_valid[i][0] && model_tag[i][0] == t) begin
                        w = 1'b0;
                end else if (model_valid[i][1] && model_tag[i][1] == t) begin
                        w = 1'b1;
                end else begin
                        exp_hit           = 1'b0;
                        w                 = !model_mru[i];
                        model_valid[i][w] = 1'b1;
                        model_tag[i][w]   = t;
                end
                model_mru[i] = w;
                if (exp_hit) begin
                        model_hits++;
                end
        endtask

        initial begin
                CLK = 1'b0;
                forever #20 CLK = ~CLK;
        end

        initial begin : watchdog
                repeat (MAX_CYCLES) @(posedge CLK);
                $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
                $display("Done: errors found");
                $finish;
        end

        initial begin : stimulus
                logic  exp_hit;
                word_t mem_word;
                nRST    = 1'b0;
                halt    = 1'b0;
                cpu_req = '0;
                for (int s = 0; s < SETS; s++) begin
                        model_valid[s][0] = 1'b0;
                        model_valid[s][1] = 1'b0;
                        model_mru[s]      = 1'b0;
                end
                repeat (10) @(posedge CLK);
                nRST <= 1'b1;
                @(negedge CLK);
                check_flag("cpu_rsp.hit", cpu_rsp.hit, 1'b0);
                check_flag("cpu_rsp.flushed", cpu_rsp.flushed, 1'b0);
                check_flag("mem_req.ren", mem_req.ren, 1'b0);
                check_flag("mem_req.wen", mem_req.wen, 1'b0);
                foreach (STEPS[n]) begin
                        mem_model.read_word(STEPS[n].addr, mem_word);
                        gold[STEPS[n].addr] = mem_word;
                end

                foreach (STEPS[n]) begin
                        predict_access(STEPS[n].addr, exp_hit);
                        @(posedge CLK);
                        cpu_req <= '{ren: !STEPS[n].wr, wen: STEPS[n].wr,
                                     addr: STEPS[n].addr, store: STEPS[n].data};
                        @(negedge CLK);
                        check_flag("cpu_rsp.hit", cpu_rsp.hit, exp_hit);
                        while (!cpu_rsp.hit) begin
                                @(negedge CLK);
                        end
                        if (STEPS[n].wr) begin
                                gold[STEPS[n].addr] = STEPS[n].data;
                        end else begin
                                check_word("cpu_rsp.load", cpu_rsp.load, gold[STEPS[n].addr]);
                        end
                end

                @(posedge CLK);
                cpu_req <= '0;
                halt    <= 1'b1;
                @(negedge CLK);
                while (!cpu_rsp.flushed) begin
                        @(negedge CLK);
                end
                repeat (4) begin
                        @(negedge CLK);
                        check_flag("cpu_rsp.flushed", cpu_rsp.flushed, 1'b1);
                end
                foreach (gold[a]) begin
                        mem_model.read_word(a, mem_word);
                        check_word($sformatf("mem[%h]", a), mem_word, gold[a]);
                end
                mem_model.read_word(HIT_COUNT_ADDR, mem_word);
                check_word("hit count", mem_word, word_t'(model_hits));

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

// ==== dcache.f ====
hw/dcache_pkg.sv
hw/dcache_tag_lookup.sv
hw/dcache_frames.sv
hw/dcache_control.sv
hw/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= dcache.f
TB_TOP    ?= dcache_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	./$(BUILD_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TB_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
